// ==== compile.f ====
+incdir+dv
common/soc_pkg.sv
source/address_decoder.sv
source/bus_controller.sv
ram/onchip_ram.sv
plic/plic.sv
source/soc_bus_top.sv
dv/tb_soc_bus.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_soc_bus
FILELIST  = compile.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_soc_bus_checks.svh ====
// included into tb_soc_bus, uses its signals directly

// state on the first edge out of reset
a_reset_flags: assert property (@(posedge CLOCK_50)
    $rose(KEY0) |-> bus_read_done && bus_write_done && !meip && !msip)
    else begin
        errors++;
        $display("Fail %0t {bus_read_done, bus_write_done, meip, msip} expected 1100 got %b",
                 $time, $sampled({bus_read_done, bus_write_done, meip, msip}));
    end

a_reset_mtimecmp: assert property (@(posedge CLOCK_50)
    $rose(KEY0) |-> mtimecmp == MTIMECMP_RESET)
    else begin
        errors++;
        $display("Fail %0t mtimecmp expected %h got %h", $time, MTIMECMP_RESET,
                 $sampled(mtimecmp));
    end

// done falls one edge after the enable, rises at N+2 or N+3 for doubles
a_read_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    (bus_read_enable && !exp_double) |=> bus_read_done ##1 !bus_read_done ##1 bus_read_done)
    else begin
        errors++;
        $display("%0t: read done timing wrong for a single access", $time);
    end

a_read_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    (bus_read_enable && exp_double) |=>
        bus_read_done ##1 !bus_read_done ##1 !bus_read_done ##1 bus_read_done)
    else begin
        errors++;
        $display("%0t: read done timing wrong for ld", $time);
    end

a_write_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    (bus_write_enable && !exp_double) |=> bus_write_done ##1 !bus_write_done ##1 bus_write_done)
    else begin
        errors++;
        $display("%0t: write done timing wrong for a single access", $time);
    end

a_write_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    (bus_write_enable && exp_double) |=>
        bus_write_done ##1 !bus_write_done ##1 !bus_write_done ##1 bus_write_done)
    else begin
        errors++;
        $display("%0t: write done timing wrong for sd", $time);
    end

a_read_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    ($rose(bus_read_done) && check_rdata) |-> bus_read_data == exp_rdata)
    else begin
        errors++;
        $display("Fail %0t bus_read_data expected %h got %h", $time, $sampled(exp_rdata),
                 $sampled(bus_read_data));
    end

a_mtimecmp: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    $rose(bus_write_done) |-> mtimecmp == exp_mtimecmp)
    else begin
        errors++;
        $display("Fail %0t mtimecmp expected %h got %h", $time, $sampled(exp_mtimecmp),
                 $sampled(mtimecmp));
    end

a_fetch: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    fetch_check_q |-> instruction == exp_instr_q)
    else begin
        errors++;
        $display("Fail %0t instruction expected %h got %h", $time, $sampled(exp_instr_q),
                 $sampled(instruction));
    end

a_meip: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    irq_check |-> meip == exp_meip)
    else begin
        errors++;
        $display("Fail %0t meip expected %b got %b", $time, $sampled(exp_meip), $sampled(meip));
    end

a_msip: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
    irq_check |-> msip == exp_msip)
    else begin
        errors++;
        $display("Fail %0t msip expected %b got %b", $time, $sampled(exp_msip), $sampled(msip));
    end

// ==== dv/tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus import soc_pkg::*; ();

    localparam int RAM_WORDS   = 2048;
    localparam int MODEL_WORDS = 32;  // window of RAM that the random traffic uses
    localparam int TIMEOUT     = 50;

    logic     CLOCK_50;
    logic     KEY0;
    addr_t    bus_address;
    data_t    bus_write_data;
    ls_type_e bus_ls_type;
    logic     bus_read_enable;
    logic     bus_write_enable;
    logic     bus_read_done;
    logic     bus_write_done;
    data_t    bus_read_data;
    addr_t    fetch_address;
    word_t    instruction;
    data_t    mtime;
    data_t    mtimecmp;
    logic     meip;
    logic     msip;
    logic     irq;

    // expected values, read by the checks
    word_t    model [MODEL_WORDS];
    data_t    exp_rdata;
    data_t    exp_mtimecmp;
    word_t    exp_instr;
    word_t    exp_instr_q;
    logic     exp_double;
    logic     exp_meip;
    logic     exp_msip;
    logic     check_rdata;
    logic     fetch_check;
    logic     fetch_check_q;
    logic     irq_check;
    int       errors;
    int       timeouts;
    int       accesses;

    soc_bus_top #(.RAM_WORDS(RAM_WORDS), .NUM_SOURCES(6)) soc_bus_top_i (.*);

    `include "tb_soc_bus_checks.svh"

    always #4 CLOCK_50 = ~CLOCK_50;

    // fetch result shows one cycle after the address
    always @(posedge CLOCK_50) begin
        fetch_check_q <= fetch_check;
        exp_instr_q   <= exp_instr;
    end

    function automatic word_t byte_reverse(word_t w);
        word_t r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = w[8*(3-i) +: 8];
        end
        return r;
    endfunction

    function automatic void model_store(addr_t a, data_t d, ls_type_e ls);
        int idx;
        int off;
        idx = int'(a[6:2]);
        off = int'(a[1:0]);
        case (ls)
            LS_SB: model[idx][8*off +: 8] = d[7:0];
            LS_SH: begin
                if (off == 0) begin
                    model[idx][15:0] = d[15:0];
                end else if (off == 2) begin
                    model[idx][31:16] = d[15:0];
                end // odd offset, no write
            end
            LS_SW: model[idx] = d[31:0];
            default: begin
                model[idx]     = d[31:0];
                model[idx + 1] = d[63:32];
            end
        endcase
    endfunction

    function automatic data_t model_load(addr_t a, ls_type_e ls);
        int idx;
        idx = int'(a[6:2]);
        if (ls == LS_LD) begin
            return {model[idx + 1], model[idx]};
        end
        return {32'd0, model[idx] >> (8 * int'(a[1:0]))};
    endfunction

    task automatic wait_done(input logic is_write, input logic level);
        int   cycles;
        logic d;
        cycles = 0;
        d      = ~level;
        while (d != level && timeouts == 0) begin
            @(posedge CLOCK_50);
            d = is_write ? bus_write_done : bus_read_done;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("%0t: timeout, %s done never went to %0d", $time,
                         is_write ? "write" : "read", level);
                timeouts++;
            end
        end
    endtask

    task automatic bus_access(input logic is_write, input addr_t addr, input data_t wdata,
                              input ls_type_e ls, input data_t expect_data);
        if (timeouts != 0) return;
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_write_data   <= wdata;
        bus_ls_type      <= ls;
        exp_double       <= (ls == LS_LD) && (addr < addr_t'(4 * RAM_WORDS));
        exp_rdata        <= expect_data;
        check_rdata      <= !is_write;
        bus_read_enable  <= !is_write;
        bus_write_enable <= is_write;
        @(posedge CLOCK_50);
        bus_read_enable  <= 1'b0; // single-cycle pulse
        bus_write_enable <= 1'b0;
        wait_done(is_write, 1'b0);
        wait_done(is_write, 1'b1);
        accesses++;
    endtask

    task automatic store(input addr_t addr, input data_t wdata, input ls_type_e ls);
        bus_access(1'b1, addr, wdata, ls, '0);
    endtask

    task automatic load(input addr_t addr, input ls_type_e ls, input data_t expect_data);
        bus_access(1'b0, addr, '0, ls, expect_data);
    endtask

    task automatic fetch_word_check(input int idx);
        @(posedge CLOCK_50);
        fetch_address <= addr_t'(4 * idx);
        exp_instr     <= byte_reverse(model[idx]);
        fetch_check   <= 1'b1;
        @(posedge CLOCK_50);
        fetch_check <= 1'b0;
    endtask

    task automatic expect_irq(input logic m, input logic s);
        @(posedge CLOCK_50);
        exp_meip  <= m;
        exp_msip  <= s;
        irq_check <= 1'b1;
        @(posedge CLOCK_50);
        irq_check <= 1'b0;
    endtask

    // pulse the line, wait for the context's output, then check both outputs
    task automatic raise_irq(input logic ctx);
        int cycles;
        cycles = 0;
        if (timeouts != 0) return;
        @(posedge CLOCK_50);
        irq <= 1'b1;
        @(posedge CLOCK_50);
        irq <= 1'b0;
        while (!(ctx ? msip : meip) && timeouts == 0) begin
            @(posedge CLOCK_50);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("%0t: timeout, interrupt output of context %0d never rose", $time, ctx);
                timeouts++;
            end
        end
        expect_irq(!ctx, ctx);
    endtask

    initial begin
        addr_t    a;
        data_t    d;
        ls_type_e ls;
        int       kind;
        void'($urandom(55));
        CLOCK_50         = 1'b0;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = LS_LW;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        fetch_address    = '0;
        mtime            = '0;
        irq              = 1'b0;
        exp_rdata        = '0;
        exp_mtimecmp     = MTIMECMP_RESET;
        exp_instr        = '0;
        exp_double       = 1'b0;
        exp_meip         = 1'b0;
        exp_msip         = 1'b0;
        check_rdata      = 1'b0;
        fetch_check      = 1'b0;
        irq_check        = 1'b0;
        errors           = 0;
        timeouts         = 0;
        accesses         = 0;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // known contents for the model window
        for (int i = 0; i < MODEL_WORDS; i++) begin
            d = {$urandom, $urandom};
            model_store(addr_t'(4 * i), d, LS_SW);
            store(addr_t'(4 * i), d, LS_SW);
            fetch_word_check(i);
        end

        for (int n = 0; n < 60; n++) begin
            a = addr_t'(4 * ($urandom % MODEL_WORDS) + $urandom % 4);
            d = {$urandom, $urandom};
            if ($urandom % 2 == 0) begin
                ls = ls_type_e'($urandom % 3); // sb, sh, sw
                model_store(a, d, ls);
                store(a, d, ls);
                fetch_word_check(int'(a[6:2]));
            end else begin
                kind = $urandom % 6;
                ls   = ls_type_e'(kind < 3 ? kind : kind + 1); // skip ld
                load(a, ls, model_load(a, ls));
            end
        end

        // two-beat doubles
        for (int n = 0; n < 4; n++) begin
            a = addr_t'(8 * ($urandom % (MODEL_WORDS / 2)));
            d = {$urandom, $urandom};
            model_store(a, d, LS_SD);
            store(a, d, LS_SD);
            load(a, LS_LD, model_load(a, LS_LD));
        end

        // timer
        d = {$urandom, $urandom};
        @(posedge CLOCK_50);
        mtime <= d;
        load(MTIME_ADDR, LS_LD, d);
        d = {$urandom, $urandom};
        exp_mtimecmp <= d;
        store(MTIMECMP_ADDR, d, LS_SD);
        load(MTIMECMP_ADDR, LS_LD, d);

        // interrupt controller, context 0 then context 1
        store(PLIC_BASE + 64'd4, 64'd5, LS_SW);
        load(PLIC_BASE + 64'd4, LS_LW, 64'd5);
        store(PLIC_ENABLE, 64'd2, LS_SW);
        load(PLIC_ENABLE, LS_LW, 64'd2);
        raise_irq(1'b0);
        load(PLIC_CLAIM, LS_LW, 64'd1);
        expect_irq(1'b0, 1'b0);
        store(PLIC_ENABLE, 64'd0, LS_SW);
        store(PLIC_ENABLE + PLIC_ENABLE_STRIDE, 64'd2, LS_SW);
        raise_irq(1'b1);
        load(PLIC_CLAIM + PLIC_CTX_STRIDE, LS_LW, 64'd1);
        expect_irq(1'b0, 1'b0);

        // nothing mapped here
        load(64'h1000_0000, LS_LW, 64'd0);
        store(64'h1000_0000, {$urandom, $urandom}, LS_SW);

        @(posedge CLOCK_50);
        $display("accesses %0d, errors %0d, timeouts %0d", accesses, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== source/soc_bus_top.sv ====
`timescale 1ns/100ps

module soc_bus_top import soc_pkg::*; #(
    parameter int RAM_WORDS   = 2048,
    parameter int NUM_SOURCES = 6
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  addr_t    bus_address,
    input  data_t    bus_write_data,
    input  ls_type_e bus_ls_type,
    input  logic     bus_read_enable,
    input  logic     bus_write_enable,
    output logic     bus_read_done,
    output logic     bus_write_done,
    output data_t    bus_read_data,
    input  addr_t    fetch_address,
    output word_t    instruction,
    input  data_t    mtime,
    output data_t    mtimecmp,
    output logic     meip,
    output logic     msip,
    input  logic     irq          // external line, feeds source 1
);

    target_e target;
    data_t   ram_rdata;
    logic    ram_done;
    logic    ram_read_active;
    logic    ram_write_active;
    logic    plic_read;
    logic    plic_write;
    addr_t   plic_offset;
    word_t   plic_rdata;

    address_decoder #(.RAM_WORDS(RAM_WORDS)) address_decoder_i (
        .bus_address (bus_address),
        .target      (target)
    );

    bus_controller bus_controller_i (
        .CLOCK_50, .KEY0, .bus_read_enable, .bus_write_enable, .bus_address,
        .bus_write_data, .target, .mtime, .ram_rdata, .ram_done, .plic_rdata,
        .bus_read_done, .bus_write_done, .bus_read_data, .mtimecmp,
        .ram_read_active, .ram_write_active, .plic_read, .plic_write, .plic_offset
    );

    onchip_ram #(.RAM_WORDS(RAM_WORDS)) onchip_ram_i (
        .CLOCK_50, .KEY0, .fetch_address, .ram_read_active, .ram_write_active,
        .bus_address, .bus_ls_type, .bus_write_data,
        .instruction, .ram_rdata, .ram_done
    );

    plic #(.NUM_SOURCES(NUM_SOURCES)) plic_i (
        .CLOCK_50, .KEY0, .irq, .plic_read, .plic_write, .plic_offset,
        .bus_write_data, .plic_rdata, .meip, .msip
    );

endmodule

// ==== plic/plic.sv ====
`timescale 1ns/100ps

module plic import soc_pkg::*; #(
    parameter int NUM_SOURCES = 6
) (
    input  logic  CLOCK_50,
    input  logic  KEY0,
    input  logic  irq,
    input  logic  plic_read,
    input  logic  plic_write,
    input  addr_t plic_offset,
    input  data_t bus_write_data,
    output word_t plic_rdata,
    output logic  meip,
    output logic  msip
);

    localparam int    ID_W          = $clog2(NUM_SOURCES);
    localparam addr_t OFF_PENDING   = PLIC_PENDING - PLIC_BASE;
    localparam addr_t OFF_ENABLE    = PLIC_ENABLE - PLIC_BASE;
    localparam addr_t OFF_THRESHOLD = PLIC_THRESHOLD - PLIC_BASE;
    localparam addr_t OFF_CLAIM     = PLIC_CLAIM - PLIC_BASE;

    logic [2:0]             prio [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] pending;
    word_t                  enable [2];    // context 0 is M, 1 is S
    logic [2:0]             threshold [2];
    word_t                  claim_id [2];
    logic                   irq_q;
    logic                   prio_sel;
    logic                   pending_sel;
    logic [1:0]             enable_sel;
    logic [1:0]             thresh_sel;
    logic [1:0]             claim_sel;
    logic [ID_W-1:0]        prio_id;

    assign prio_sel    = plic_offset < addr_t'(4 * NUM_SOURCES);
    assign prio_id     = plic_offset[ID_W+1:2];
    assign pending_sel = (plic_offset == OFF_PENDING);

    for (genvar c = 0; c < 2; c++) begin : g_ctx
        assign enable_sel[c] = (plic_offset == OFF_ENABLE + addr_t'(c) * PLIC_ENABLE_STRIDE);
        assign thresh_sel[c] = (plic_offset == OFF_THRESHOLD + addr_t'(c) * PLIC_CTX_STRIDE);
        assign claim_sel[c]  = (plic_offset == OFF_CLAIM + addr_t'(c) * PLIC_CTX_STRIDE);
        // only source 1 is wired
        assign claim_id[c]   = (pending[1] && enable[c][1]) ? word_t'(1) : '0;
    end

    assign meip = (claim_id[0] != '0);
    assign msip = (claim_id[1] != '0);

    always_comb begin
        plic_rdata = '0;
        if (prio_sel) begin
            plic_rdata = word_t'(prio[prio_id]);
        end else if (pending_sel) begin
            plic_rdata = word_t'(pending);
        end
        for (int c = 0; c < 2; c++) begin
            if (enable_sel[c]) plic_rdata = enable[c];
            if (thresh_sel[c]) plic_rdata = word_t'(threshold[c]);
            if (claim_sel[c])  plic_rdata = claim_id[c];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_q   <= 1'b0;
            pending <= '0;
            for (int i = 0; i < NUM_SOURCES; i++) prio[i] <= '0;
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            irq_q <= irq;
            if (plic_write) begin
                if (prio_sel) prio[prio_id] <= bus_write_data[2:0];
                for (int c = 0; c < 2; c++) begin
                    if (enable_sel[c]) enable[c] <= bus_write_data[31:0];
                    if (thresh_sel[c]) threshold[c] <= bus_write_data[2:0];
                end // claim writes just complete
            end
            if (plic_read) begin
                for (int c = 0; c < 2; c++) begin
                    if (claim_sel[c] && claim_id[c] != '0) pending[claim_id[c][ID_W-1:0]] <= 1'b0;
                end
            end
            if (irq && !irq_q) pending[1] <= 1'b1; // new edge wins over a claim
        end
    end

    a_meip_pending: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        meip |-> pending[1])
        else $error("plic: meip without pending source");

    // a claim read drops meip unless irq rose in the same cycle
    a_claim_clears: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (plic_read && claim_sel[0] && meip && !(irq && !irq_q)) |=> !meip)
        else $error("plic: claim did not clear meip");

endmodule

// ==== ram/onchip_ram.sv ====
`timescale 1ns/100ps

module onchip_ram import soc_pkg::*; #(
    parameter int RAM_WORDS = 2048
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  addr_t    fetch_address,
    input  logic     ram_read_active,
    input  logic     ram_write_active,
    input  addr_t    bus_address,
    input  ls_type_e bus_ls_type,
    input  data_t    bus_write_data,
    output word_t    instruction,
    output data_t    ram_rdata,
    output logic     ram_done
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    word_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] word_addr; // registered data-port word index
    logic [IDX_W-1:0] cur_idx;
    logic [IDX_W-1:0] fetch_idx;
    logic             beat;      // second beat of ld / sd
    logic             active;
    logic             is_double;
    logic [1:0]       byte_off;
    word_t            cur_word;
    word_t            low_word;  // first beat of ld
    word_t            fetch_word;
    word_t            store_word;
    logic [3:0]       byte_we;

    assign active    = ram_read_active || ram_write_active;
    assign is_double = (bus_ls_type == LS_LD); // same code for sd
    assign byte_off  = bus_address[1:0];
    assign cur_idx   = word_addr + IDX_W'(beat);
    assign cur_word  = mem[cur_idx];
    assign fetch_idx = fetch_address[IDX_W+1:2];

    // single accesses finish in their first cycle, doubles in the second
    assign ram_done = active && (!is_double || beat);

    always_comb begin
        if (is_double) begin
            ram_rdata = {cur_word, low_word};
        end else begin
            ram_rdata = {32'd0, cur_word >> {byte_off, 3'b000}};
        end
    end

    // lane enables and replicated store data
    always_comb begin
        byte_we    = 4'b0000;
        store_word = bus_write_data[31:0];
        case (bus_ls_type)
            LS_SB: begin
                byte_we    = 4'b0001 << byte_off;
                store_word = {4{bus_write_data[7:0]}};
            end
            LS_SH: begin
                if (byte_off == 2'd0) begin
                    byte_we = 4'b0011;
                end else if (byte_off == 2'd2) begin
                    byte_we = 4'b1100;
                end // odd offsets write nothing
                store_word = {2{bus_write_data[15:0]}};
            end
            LS_SW: byte_we = 4'b1111;
            LS_SD: begin
                byte_we    = 4'b1111;
                store_word = beat ? bus_write_data[63:32] : bus_write_data[31:0];
            end
            default: byte_we = 4'b0000;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat      <= 1'b0;
            word_addr <= '0;
        end else begin
            word_addr <= bus_address[IDX_W+1:2];
            if (ram_done) begin
                beat <= 1'b0;
            end else if (active && is_double) begin
                beat <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        fetch_word <= mem[fetch_idx];
        if (ram_read_active && !beat) begin
            low_word <= cur_word;
        end
        if (ram_write_active) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_we[b]) begin
                    mem[cur_idx][8*b +: 8] <= store_word[8*b +: 8];
                end
            end
        end
    end

    // fetch word comes out byte-swapped
    assign instruction = {fetch_word[7:0], fetch_word[15:8],
                          fetch_word[23:16], fetch_word[31:24]};

    // a double only completes after a full first beat
    a_done_needs_access: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ram_done |-> active && (!is_double || $past(active)))
        else $error("onchip_ram: done without an active access");

endmodule

// ==== source/bus_controller.sv ====
`timescale 1ns/100ps

module bus_controller import soc_pkg::*; (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  logic    bus_read_enable,
    input  logic    bus_write_enable,
    input  addr_t   bus_address,
    input  data_t   bus_write_data,
    input  target_e target,
    input  data_t   mtime,
    input  data_t   ram_rdata,
    input  logic    ram_done,
    input  word_t   plic_rdata,
    output logic    bus_read_done,
    output logic    bus_write_done,
    output data_t   bus_read_data,
    output data_t   mtimecmp,
    output logic    ram_read_active,
    output logic    ram_write_active,
    output logic    plic_read,
    output logic    plic_write,
    output addr_t   plic_offset
);

    logic  rd_req;  // enable seen, done drops next edge
    logic  wr_req;
    logic  rd_pend;
    logic  wr_pend;
    logic  rd_fin;
    logic  wr_fin;
    data_t rd_mux;

    // single-cycle targets finish right away, RAM waits for its done
    assign rd_fin = rd_pend && ((target != TGT_RAM) || ram_done);
    assign wr_fin = wr_pend && ((target != TGT_RAM) || ram_done);

    assign ram_read_active  = rd_pend && (target == TGT_RAM);
    assign ram_write_active = wr_pend && (target == TGT_RAM);

    // plic accesses last one cycle, so these are strobes
    assign plic_read   = rd_pend && (target == TGT_PLIC);
    assign plic_write  = wr_pend && (target == TGT_PLIC);
    assign plic_offset = bus_address - PLIC_BASE;

    always_comb begin
        case (target)
            TGT_RAM:      rd_mux = ram_rdata;
            TGT_MTIME:    rd_mux = mtime;
            TGT_MTIMECMP: rd_mux = mtimecmp;
            TGT_PLIC:     rd_mux = {32'd0, plic_rdata};
            default:      rd_mux = '0; // unmapped reads as zero
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_req         <= 1'b0;
            wr_req         <= 1'b0;
            rd_pend        <= 1'b0;
            wr_pend        <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            mtimecmp       <= MTIMECMP_RESET;
        end else begin
            rd_req <= bus_read_enable;
            wr_req <= bus_write_enable;

            if (rd_req) begin
                bus_read_done <= 1'b0;
                rd_pend       <= 1'b1;
            end else if (rd_fin) begin
                bus_read_done <= 1'b1;
                rd_pend       <= 1'b0;
            end

            if (wr_req) begin
                bus_write_done <= 1'b0;
                wr_pend        <= 1'b1;
            end else if (wr_fin) begin
                bus_write_done <= 1'b1;
                wr_pend        <= 1'b0;
            end

            if (wr_fin && (target == TGT_MTIMECMP)) begin
                mtimecmp <= bus_write_data;
            end
        end
    end

    // read data holds until the next read completes
    always_ff @(posedge CLOCK_50) begin
        if (rd_fin) begin
            bus_read_data <= rd_mux;
        end
    end

    // the core never overlaps a load and a store
    a_no_rd_wr_overlap: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(rd_pend && wr_pend))
        else $error("bus_controller: read and write pending together");

endmodule

// ==== source/address_decoder.sv ====
`timescale 1ns/100ps

module address_decoder import soc_pkg::*; #(
    parameter int RAM_WORDS = 2048
) (
    input  addr_t   bus_address,
    output target_e target
);

    localparam addr_t RAM_END = RAM_BASE + addr_t'(4 * RAM_WORDS);

    logic ram_hit;
    logic plic_hit;
    logic mtime_hit;
    logic mtimecmp_hit;

    // ranges for the RAM and PLIC windows, exact words for the timer
    assign ram_hit      = (bus_address >= RAM_BASE) && (bus_address < RAM_END);
    assign plic_hit     = (bus_address >= PLIC_BASE) && (bus_address < PLIC_SPAN);
    assign mtime_hit    = (bus_address == MTIME_ADDR);
    assign mtimecmp_hit = (bus_address == MTIMECMP_ADDR);

    always_comb begin
        target = TGT_NONE; // unmapped, answered with zero
        if (ram_hit) begin
            target = TGT_RAM;
        end else if (plic_hit) begin
            target = TGT_PLIC;
        end else if (mtime_hit) begin
            target = TGT_MTIME;
        end else if (mtimecmp_hit) begin
            target = TGT_MTIMECMP;
        end
    end

    // the map must not overlap, whatever RAM_WORDS is set to at the top
    always_comb begin
        assert ($onehot0({ram_hit, plic_hit, mtime_hit, mtimecmp_hit}))
            else $error("address_decoder: overlapping windows at %h", bus_address);
    end

endmodule

// ==== common/soc_pkg.sv ====
package soc_pkg;

    // bus widths
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int WORD_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [WORD_W-1:0] word_t;

    // load codes, stores reuse 0..3
    typedef enum logic [2:0] {
        LS_LB  = 3'd0,
        LS_LH  = 3'd1,
        LS_LW  = 3'd2,
        LS_LD  = 3'd3,
        LS_LBU = 3'd4,
        LS_LHU = 3'd5,
        LS_LWU = 3'd6
    } ls_type_e;

    localparam ls_type_e LS_SB = LS_LB;
    localparam ls_type_e LS_SH = LS_LH;
    localparam ls_type_e LS_SW = LS_LW;
    localparam ls_type_e LS_SD = LS_LD;

    typedef enum logic [2:0] {
        TGT_RAM,
        TGT_MTIME,
        TGT_MTIMECMP,
        TGT_PLIC,
        TGT_NONE
    } target_e;

    // address map
    localparam addr_t RAM_BASE           = 64'h0;
    localparam addr_t MTIMECMP_ADDR      = 64'h0200_4000;
    localparam addr_t MTIME_ADDR         = 64'h0200_BFF8;
    localparam addr_t PLIC_BASE          = 64'h0C00_0000;
    localparam addr_t PLIC_PENDING       = PLIC_BASE + 64'h1000;
    localparam addr_t PLIC_ENABLE        = PLIC_BASE + 64'h2000;
    localparam addr_t PLIC_THRESHOLD     = PLIC_BASE + 64'h20_0000;
    localparam addr_t PLIC_CLAIM         = PLIC_BASE + 64'h20_0004;
    localparam addr_t PLIC_ENABLE_STRIDE = 64'h80;   // per context
    localparam addr_t PLIC_CTX_STRIDE    = 64'h1000; // threshold and claim per context
    localparam addr_t PLIC_SPAN          = PLIC_THRESHOLD + 64'h2000;

    localparam data_t MTIMECMP_RESET = 64'h8000_0000;

endpackage
